// File: hdl/quad_ctrl_pkg.sv
`default_nettype none

package quad_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ROW_BUF_DEPTH    = 1024;
    localparam int ROW_ADDR_W       = $clog2(ROW_BUF_DEPTH);
    // 4 engines per array, 2 arrays
    localparam int NUM_CE           = 4 * 2;
    localparam int WINDOW_CYCLES    = 9;
    localparam int WIN_CNT_W        = $clog2(WINDOW_CYCLES);
    localparam int SEQ_ADDR_W       = 12;
    localparam int PFB_COUNT_W      = 10;
    localparam int KERNEL_W         = 5;
    localparam int PRIME_ROWS       = 3;
    // Sequence BRAM read to first engine execute
    localparam int SEQ_READ_LATENCY = 2;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_prime_buffer,
        st_wait_pfb_load,
        st_ce_active,
        st_wait_job_done,
        st_send_complete
    } ctrl_state_t;

    // Job settings, stable for the whole job
    typedef struct packed {
        logic [ROW_ADDR_W-1:0]  num_expd_input_cols;
        logic [ROW_ADDR_W-1:0]  num_expd_input_rows;
        logic [ROW_ADDR_W-1:0]  num_output_rows;
        logic [ROW_ADDR_W-1:0]  num_output_cols;
        logic [KERNEL_W-1:0]    num_kernels;
        logic [PFB_COUNT_W-1:0] pfb_full_count;
        logic [SEQ_ADDR_W-1:0]  pix_seq_full_count;
    } layer_cfg_t;

    typedef struct packed {
        logic [NUM_CE-1:0] ce_execute;
        logic [NUM_CE-1:0] next_kernel;
    } ce_strobe_t;

    typedef struct packed {
        logic                  rden;
        logic [SEQ_ADDR_W-1:0] addr;
    } seq_rd_t;

endpackage

`default_nettype wire

// File: hdl/job_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module job_ctrl_fsm
    import quad_ctrl_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  job_start,
    input  wire logic                  job_fetch_ack,
    input  wire logic                  job_fetch_complete,
    input  wire logic                  job_complete_ack,
    input  wire logic                  pipeline_flushed,
    input  wire logic                  pfb_empty,
    input  wire logic [ROW_ADDR_W-1:0] input_row,
    input  wire logic                  pass_done,
    input  wire logic                  last_kernel,
    input  wire logic                  job_rows_done,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_complete,
    output logic                       drain_en,
    output logic                       pass_start,
    output ctrl_state_t                state
);

    // State to go back to once a row fetch completes
    ctrl_state_t ret_state;
    // A new row is being drained between two output rows
    logic        row_refill;

    assign drain_en = (state == st_prime_buffer) ||
                      ((state == st_ce_active) && row_refill);

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= st_idle;
            ret_state         <= st_idle;
            row_refill        <= 1'b0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            pass_start        <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            pass_start <= 1'b0;

            case (state)
                st_idle: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= st_prime_buffer;
                    end
                end

                //////////////////////////////////////////////////////////
                // Priming, three rows before any window runs
                //////////////////////////////////////////////////////////
                st_prime_buffer: begin
                    if (pfb_empty) begin
                        if (input_row == ROW_ADDR_W'(PRIME_ROWS)) begin
                            pass_start <= 1'b1;
                            state      <= st_ce_active;
                        end else begin
                            ret_state         <= st_prime_buffer;
                            job_fetch_request <= 1'b1;
                            state             <= st_wait_pfb_load;
                        end
                    end
                end

                st_wait_pfb_load: begin
                    // Request drops the cycle after its ack
                    if (job_fetch_ack && job_fetch_request) begin
                        job_fetch_request <= 1'b0;
                    end
                    if (job_fetch_complete) begin
                        state <= ret_state;
                    end
                end

                //////////////////////////////////////////////////////////
                // Kernel-group passes and row refills
                //////////////////////////////////////////////////////////
                st_ce_active: begin
                    if (row_refill) begin
                        // Refilled row fully written, start next output row
                        if (pfb_empty) begin
                            row_refill <= 1'b0;
                            pass_start <= 1'b1;
                        end
                    end else if (pass_done) begin
                        if (job_rows_done) begin
                            state <= st_wait_job_done;
                        end else if (last_kernel) begin
                            ret_state         <= st_ce_active;
                            row_refill        <= 1'b1;
                            job_fetch_request <= 1'b1;
                            state             <= st_wait_pfb_load;
                        end else begin
                            pass_start <= 1'b1;
                        end
                    end
                end

                st_wait_job_done: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= st_send_complete;
                    end
                end

                st_send_complete: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/window_timer.sv
`timescale 1ns/1ps
`default_nettype none

module window_timer
    import quad_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire layer_cfg_t cfg,
    input  wire logic       seq_rden,
    input  wire logic       job_done_ack,
    output logic            pass_done,
    output logic            last_kernel,
    output logic            job_rows_done
);

    logic [WIN_CNT_W-1:0]  win_cyc;
    logic [ROW_ADDR_W-1:0] out_col;
    logic [ROW_ADDR_W-1:0] out_row;
    logic [KERNEL_W-1:0]   kernel_grp;
    logic                  win_end;
    logic                  pass_end;

    // Ninth sequence read closes a 3x3 window
    assign win_end  = seq_rden && (win_cyc == WIN_CNT_W'(WINDOW_CYCLES - 1));
    assign pass_end = win_end && (out_col == cfg.num_output_cols - ROW_ADDR_W'(1));

    assign last_kernel = (kernel_grp == cfg.num_kernels);

    always_ff @(posedge clk) begin
        if (rst) begin
            win_cyc       <= '0;
            out_col       <= '0;
            out_row       <= '0;
            kernel_grp    <= '0;
            pass_done     <= 1'b0;
            job_rows_done <= 1'b0;
        end else begin
            pass_done     <= pass_end;
            job_rows_done <= pass_end && last_kernel &&
                             (out_row == cfg.num_output_rows - ROW_ADDR_W'(1));

            if (job_done_ack) begin
                win_cyc    <= '0;
                out_col    <= '0;
                out_row    <= '0;
                kernel_grp <= '0;
            end else begin
                if (seq_rden) begin
                    win_cyc <= win_end ? '0 : win_cyc + WIN_CNT_W'(1);
                end
                if (win_end) begin
                    out_col <= pass_end ? '0 : out_col + ROW_ADDR_W'(1);
                end
                // Group moves on after pass_done so last_kernel holds through it
                if (pass_done) begin
                    if (last_kernel) begin
                        kernel_grp <= '0;
                        out_row    <= out_row + ROW_ADDR_W'(1);
                    end else begin
                        kernel_grp <= kernel_grp + KERNEL_W'(1);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/row_buf_fill.sv
`timescale 1ns/1ps
`default_nettype none

module row_buf_fill
    import quad_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire layer_cfg_t cfg,
    input  wire logic       job_fetch_complete,
    input  wire logic       drain_en,
    input  wire logic       job_done_ack,
    output logic            pfb_rden,
    output logic            pfb_empty,
    output logic [ROW_ADDR_W-1:0] input_row,
    output logic [ROW_ADDR_W-1:0] input_col,
    output logic [ROW_ADDR_W-1:0] row_buf_wr_addr
);

    // Words still waiting in the prefetch buffer
    logic [PFB_COUNT_W-1:0] pfb_count;
    logic                   col_wrap;

    assign pfb_empty = (pfb_count == '0);
    assign pfb_rden  = drain_en && !pfb_empty;
    assign col_wrap  = (input_col == cfg.num_expd_input_cols);

    //////////////////////////////////////////////////////////////////////
    // Prefetch word count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (job_fetch_complete) begin
            pfb_count <= cfg.pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - PFB_COUNT_W'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Input position and row-buffer write address
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            input_row       <= '0;
            input_col       <= '0;
            row_buf_wr_addr <= '0;
        end else if (job_done_ack) begin
            input_row       <= '0;
            input_col       <= '0;
            row_buf_wr_addr <= '0;
        end else if (pfb_rden) begin
            // Prefetch data lands a cycle after the read, so the address trails
            row_buf_wr_addr <= input_col;
            if (col_wrap) begin
                input_col <= '0;
                input_row <= input_row + ROW_ADDR_W'(1);
            end else begin
                input_col <= input_col + ROW_ADDR_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/pix_seq_reader.sv
`timescale 1ns/1ps
`default_nettype none

module pix_seq_reader
    import quad_ctrl_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire layer_cfg_t cfg,
    input  wire logic       pass_start,
    output seq_rd_t         seq_rd,
    output ce_strobe_t      ce
);

    logic [SEQ_ADDR_W-1:0]       words_left;
    logic [SEQ_ADDR_W-1:0]       rd_addr;
    logic                        last_word;
    // Covers the sequence BRAM read latency
    logic [SEQ_READ_LATENCY-1:0] rd_dly;
    logic [NUM_CE-2:0]           exe_sr;
    logic [NUM_CE-2:0]           nk_sr;

    assign seq_rd.rden = (words_left != '0);
    assign seq_rd.addr = rd_addr;
    assign last_word   = seq_rd.rden && (words_left == SEQ_ADDR_W'(1));

    //////////////////////////////////////////////////////////////////////
    // One pass over the pixel sequence
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            words_left <= '0;
            rd_addr    <= '0;
        end else if (pass_start) begin
            words_left <= cfg.pix_seq_full_count;
            rd_addr    <= '0;
        end else if (seq_rd.rden) begin
            words_left <= words_left - SEQ_ADDR_W'(1);
            rd_addr    <= rd_addr + SEQ_ADDR_W'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Engine strobe chains, one cycle per engine
    //////////////////////////////////////////////////////////////////////

    assign ce.ce_execute  = {exe_sr, rd_dly[SEQ_READ_LATENCY-1]};
    assign ce.next_kernel = {nk_sr, last_word};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly <= '0;
            exe_sr <= '0;
            nk_sr  <= '0;
        end else begin
            rd_dly <= {rd_dly[SEQ_READ_LATENCY-2:0], seq_rd.rden};
            exe_sr <= ce.ce_execute[NUM_CE-2:0];
            nk_sr  <= ce.next_kernel[NUM_CE-2:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/quad_bram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl
    import quad_ctrl_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire layer_cfg_t       cfg,
    input  wire logic             job_start,
    input  wire logic             job_fetch_ack,
    input  wire logic             job_fetch_complete,
    input  wire logic             job_complete_ack,
    input  wire logic             pipeline_flushed,
    output logic                  job_accept,
    output logic                  job_fetch_request,
    output logic                  job_complete,
    output logic                  pfb_rden,
    output logic [ROW_ADDR_W-1:0] input_row,
    output logic [ROW_ADDR_W-1:0] input_col,
    output logic [ROW_ADDR_W-1:0] row_buf_wr_addr,
    output seq_rd_t               seq_rd,
    output ce_strobe_t            ce,
    output logic                  last_kernel,
    output ctrl_state_t           state
);

    logic drain_en;
    logic pass_start;
    logic pfb_empty;
    logic pass_done;
    logic job_rows_done;

    job_ctrl_fsm i_fsm (
        .clk                (clk),
        .rst                (rst),
        .job_start          (job_start),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .pipeline_flushed   (pipeline_flushed),
        .pfb_empty          (pfb_empty),
        .input_row          (input_row),
        .pass_done          (pass_done),
        .last_kernel        (last_kernel),
        .job_rows_done      (job_rows_done),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .drain_en           (drain_en),
        .pass_start         (pass_start),
        .state              (state)
    );

    // Counters restart on the completion ack
    window_timer i_timer (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .seq_rden      (seq_rd.rden),
        .job_done_ack  (job_complete_ack),
        .pass_done     (pass_done),
        .last_kernel   (last_kernel),
        .job_rows_done (job_rows_done)
    );

    row_buf_fill i_fill (
        .clk                (clk),
        .rst                (rst),
        .cfg                (cfg),
        .job_fetch_complete (job_fetch_complete),
        .drain_en           (drain_en),
        .job_done_ack       (job_complete_ack),
        .pfb_rden           (pfb_rden),
        .pfb_empty          (pfb_empty),
        .input_row          (input_row),
        .input_col          (input_col),
        .row_buf_wr_addr    (row_buf_wr_addr)
    );

    pix_seq_reader i_reader (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .pass_start (pass_start),
        .seq_rd     (seq_rd),
        .ce         (ce)
    );

endmodule

`default_nettype wire

// File: tb/quad_bram_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl_chk
    import quad_ctrl_pkg::*;
(
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              job_accept,
    input wire logic              job_fetch_request,
    input wire logic              job_fetch_ack,
    input wire logic              pfb_rden,
    input wire logic [NUM_CE-1:0] ce_execute,
    input wire ctrl_state_t       state
);

    // Accept is a single-cycle strobe
    a_accept_pulse: assert property (@(posedge clk) disable iff (rst)
        job_accept |=> !job_accept) else $error("job_accept high two cycles in a row");

    a_request_drop: assert property (@(posedge clk) disable iff (rst)
        (job_fetch_request && job_fetch_ack) |=> !job_fetch_request)
        else $error("job_fetch_request held after its ack");

    a_drain_state: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> (state == st_prime_buffer || state == st_ce_active))
        else $error("pfb_rden outside priming or active state");

    // Engine chain, one cycle per engine
    for (genvar i = 1; i < NUM_CE; i++) begin : g_chain
        a_exe_shift: assert property (@(posedge clk) disable iff (rst)
            ce_execute[i] == $past(ce_execute[i-1]))
            else $error("ce_execute chain broken at bit %0d", i);
    end

endmodule

`default_nettype wire

// File: tb/quad_bram_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quad_bram_ctrl_tb
    import quad_ctrl_pkg::*;
();

    typedef struct packed {
        int fetches;
        int pfb_reads;
        int seq_reads;
        int kernel_passes;
    } totals_t;

    logic clk, rst, job_start, job_fetch_ack, job_fetch_complete;
    logic job_complete_ack, pipeline_flushed;
    logic job_accept, job_fetch_request, job_complete, pfb_rden, last_kernel;
    logic [ROW_ADDR_W-1:0] input_row, input_col, row_buf_wr_addr;
    layer_cfg_t  cfg;
    seq_rd_t     seq_rd;
    ce_strobe_t  ce;
    ctrl_state_t state;
    int errors = 0;
    int jobs_run = 0;

    quad_bram_ctrl i_dut (.*);

    bind quad_bram_ctrl quad_bram_ctrl_chk i_chk (
        .clk(clk), .rst(rst), .job_accept(job_accept),
        .job_fetch_request(job_fetch_request), .job_fetch_ack(job_fetch_ack),
        .pfb_rden(pfb_rden), .ce_execute(ce.ce_execute), .state(state)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected event totals for one job
    function automatic totals_t expected_totals(layer_cfg_t c);
        totals_t t;
        t.fetches       = int'(c.num_expd_input_rows) + 1;
        t.pfb_reads     = t.fetches * int'(c.pfb_full_count);
        t.kernel_passes = int'(c.num_output_rows) * (int'(c.num_kernels) + 1);
        t.seq_reads     = t.kernel_passes * int'(c.pix_seq_full_count);
        return t;
    endfunction

    function automatic layer_cfg_t make_cfg(int cols, int rows, int out_cols, int kern);
        layer_cfg_t c;
        c.num_expd_input_cols = ROW_ADDR_W'(cols);
        c.num_expd_input_rows = ROW_ADDR_W'(rows);
        c.num_output_rows     = ROW_ADDR_W'(rows - 1);
        c.num_output_cols     = ROW_ADDR_W'(out_cols);
        c.num_kernels         = KERNEL_W'(kern);
        c.pfb_full_count      = PFB_COUNT_W'(cols + 1);
        c.pix_seq_full_count  = SEQ_ADDR_W'(WINDOW_CYCLES * out_cols);
        return c;
    endfunction

    task automatic check_count(string name, int got, int exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Comparing process
    //////////////////////////////////////////////////////////////////////

    int n_fetch, n_pfb, n_rden, n_exe_top, n_nk, n_accept, pass_word;
    int exp_col, exp_row, exp_wr;
    logic prev_req, prev_cpl, prev_start_idle, prev_fetch_ack, prev_cpl_ack;
    logic exp_last;
    totals_t exp_t;

    always @(posedge clk) begin
        if (rst) begin
            prev_req = 0;
            prev_cpl = 0;
            prev_start_idle = 0;
            prev_fetch_ack = 0;
            prev_cpl_ack = 0;
            pass_word = 0;
            exp_col = 0;
            exp_row = 0;
            exp_wr = 0;
        end else begin
            assert (job_accept == prev_start_idle) else begin
                $display("Mismatch job_accept: got 0x%h expected 0x%h",
                         job_accept, prev_start_idle);
                errors++;
            end
            if (job_accept) n_accept++;
            if (job_fetch_request && !prev_req) n_fetch++;
            // Held levels only drop after their ack
            if (prev_req && !job_fetch_request) begin
                assert (prev_fetch_ack) else begin
                    $display("job_fetch_request fell without job_fetch_ack");
                    errors++;
                end
            end
            if (prev_cpl && !job_complete) begin
                assert (prev_cpl_ack) else begin
                    $display("job_complete fell without job_complete_ack");
                    errors++;
                end
            end
            if (pfb_rden) n_pfb++;
            if (ce.ce_execute[NUM_CE-1]) n_exe_top++;
            if (ce.next_kernel[0]) n_nk++;
            assert (input_col <= cfg.num_expd_input_cols) else begin
                $display("Mismatch input_col: got 0x%h limit 0x%h",
                         input_col, cfg.num_expd_input_cols);
                errors++;
            end
            assert (input_col == ROW_ADDR_W'(exp_col)) else begin
                $display("Mismatch input_col: got 0x%h expected 0x%h",
                         input_col, ROW_ADDR_W'(exp_col));
                errors++;
            end
            assert (input_row == ROW_ADDR_W'(exp_row)) else begin
                $display("Mismatch input_row: got 0x%h expected 0x%h",
                         input_row, ROW_ADDR_W'(exp_row));
                errors++;
            end
            assert (row_buf_wr_addr == ROW_ADDR_W'(exp_wr)) else begin
                $display("Mismatch row_buf_wr_addr: got 0x%h expected 0x%h",
                         row_buf_wr_addr, ROW_ADDR_W'(exp_wr));
                errors++;
            end
            // Write address trails the read by one cycle
            if (job_complete_ack) begin
                exp_col = 0;
                exp_row = 0;
                exp_wr = 0;
            end else if (pfb_rden) begin
                exp_wr = exp_col;
                if (exp_col == int'(cfg.num_expd_input_cols)) begin
                    exp_col = 0;
                    exp_row++;
                end else begin
                    exp_col++;
                end
            end
            if (seq_rd.rden) begin
                exp_last = ((n_rden / int'(cfg.pix_seq_full_count)) %
                            (int'(cfg.num_kernels) + 1)) == int'(cfg.num_kernels);
                assert (last_kernel == exp_last) else begin
                    $display("Mismatch last_kernel: got 0x%h expected 0x%h",
                             last_kernel, exp_last);
                    errors++;
                end
                n_rden++;
                assert (seq_rd.addr == SEQ_ADDR_W'(pass_word)) else begin
                    $display("Mismatch seq_rd.addr: got 0x%h expected 0x%h",
                             seq_rd.addr, pass_word);
                    errors++;
                end
                pass_word = (pass_word + 1) % int'(cfg.pix_seq_full_count);
            end
            // All strobes have settled by the time the flush is reported
            if (job_complete && !prev_cpl) begin
                assert (pipeline_flushed) else begin
                    $display("job_complete rose before pipeline_flushed");
                    errors++;
                end
                exp_t = expected_totals(cfg);
                check_count("job_accept", n_accept, 1);
                check_count("job_fetch_request", n_fetch, exp_t.fetches);
                check_count("pfb_rden", n_pfb, exp_t.pfb_reads);
                check_count("seq_rd.rden", n_rden, exp_t.seq_reads);
                check_count("ce_execute_top", n_exe_top, exp_t.seq_reads);
                check_count("next_kernel", n_nk, exp_t.kernel_passes);
            end
            prev_req = job_fetch_request;
            prev_cpl = job_complete;
            prev_fetch_ack = job_fetch_ack;
            prev_cpl_ack = job_complete_ack;
            prev_start_idle = job_start && (state == st_idle);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Host and fetch model
    //////////////////////////////////////////////////////////////////////

    task automatic run_job(layer_cfg_t c, output logic ok);
        int fetch_phase, delay, flush_dly, ack_dly, cyc;
        fetch_phase = 0;
        delay = 0;
        flush_dly = -1;
        ack_dly = -1;
        ok = 0;
        n_fetch = 0;
        n_pfb = 0;
        n_rden = 0;
        n_exe_top = 0;
        n_nk = 0;
        n_accept = 0;
        cfg = c;
        job_start = 1'b1;
        for (cyc = 0; cyc < 200000 && !ok; cyc++) begin
            @(posedge clk);
            #2;
            job_fetch_ack = 1'b0;
            job_fetch_complete = 1'b0;
            if (job_accept) job_start = 1'b0;
            // Fetch phases are idle, waiting to ack and waiting to complete
            if (fetch_phase == 0 && job_fetch_request) begin
                delay = $urandom_range(6, 1);
                fetch_phase = 1;
            end
            if (fetch_phase != 0) begin
                delay--;
            end
            if (fetch_phase == 1 && delay == 0) begin
                job_fetch_ack = 1'b1;
                delay = $urandom_range(8, 2);
                fetch_phase = 2;
            end else if (fetch_phase == 2 && delay == 0) begin
                job_fetch_complete = 1'b1;
                fetch_phase = 0;
            end
            if (state == st_wait_job_done && flush_dly < 0) begin
                flush_dly = 12 + $urandom_range(7, 0);
            end
            if (flush_dly > 0) begin
                flush_dly--;
                if (flush_dly == 0) begin
                    pipeline_flushed = 1'b1;
                end
            end
            if (job_complete_ack) begin
                job_complete_ack = 1'b0;
                pipeline_flushed = 1'b0;
                ok = (state == st_idle);
                if (!ok) begin
                    $display("state did not return to idle after the completion ack");
                    errors++;
                    ok = 1;
                end
            end else if (job_complete) begin
                if (ack_dly < 0) begin
                    ack_dly = $urandom_range(4, 1);
                end
                ack_dly--;
                if (ack_dly == 0) begin
                    job_complete_ack = 1'b1;
                end
            end
        end
        jobs_run++;
    endtask

    initial begin
        logic ok;
        void'($urandom(68));
        rst = 1'b1;
        job_start = 1'b0;
        job_fetch_ack = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack = 1'b0;
        pipeline_flushed = 1'b0;
        cfg = make_cfg(7, 5, 6, 2);
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #2;
            assert (!job_accept && !job_fetch_request && !job_complete && !pfb_rden &&
                     !seq_rd.rden && ce == '0 && state == st_idle) else begin
                $display("Control outputs not quiet in idle after reset");
                errors++;
            end
        end
        run_job(make_cfg(7, 5, 6, 2), ok);
        if (ok) run_job(make_cfg(11, 6, 10, 1), ok);
        $display("Checks: %0d errors over %0d jobs", errors, jobs_run);
        if (!ok) begin
            $display("Timeout waiting for job completion");
            $display("Done: errors found");
        end else if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: quad_bram_ctrl.f
hdl/quad_ctrl_pkg.sv
hdl/job_ctrl_fsm.sv
hdl/window_timer.sv
hdl/row_buf_fill.sv
hdl/pix_seq_reader.sv
hdl/quad_bram_ctrl.sv
tb/quad_bram_ctrl_chk.sv
tb/quad_bram_ctrl_tb.sv

// File: Makefile
TOP = quad_bram_ctrl_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f quad_bram_ctrl.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing --assert -f quad_bram_ctrl.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir
